//--- bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock
module tb_clkgen #(
   parameter int PERIOD_NS = 10
) (
   output logic clk_o
);

   // Start low so the first rising edge lands at half a period
   initial begin
      clk_o = 1'b0;
   end

   always begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- bench/tb_harvard_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the Harvard memory subsystem
module tb_harvard_mem
   import mem_pkg::*;
   import fetch_pkg::*;
();

   // Planned transactions per test for the watchdog
   localparam int PLANNED_TXN = 32 + 32 + 156 + 64 + 30;
   localparam int CLK_NS      = 10;

   logic   clk;
   logic   wb_rst_i;
   logic   host_stb_i;
   logic   host_we_i;
   logic   host_ack_o;
   logic   host_busy_o;
   addr_t  host_adr_i;
   sel_t   host_sel_i;
   word_t  host_dat_i;
   word_t  host_dat_o;
   logic   fetch_start_i;
   logic   fetch_stop_i;
   logic   fetch_stall_i;
   logic   instr_valid_o;
   addr_t  fetch_pc_i;
   addr_t  instr_pc_o;
   instr_t instr_o;

   // Reference memory with one entry per written word
   word_t       model [int];
   logic [31:0] lcg_state;
   int          errors;
   int          test_no;
   int          tests_failed;
   int          errors_at_start;
   int          prog_base;

   tb_clkgen #(.PERIOD_NS(CLK_NS)) u_clkgen (.clk_o(clk));

   harvard_mem_top u_dut (
      .wb_clk_i     (clk),
      .wb_rst_i     (wb_rst_i),
      .host_stb_i   (host_stb_i),
      .host_we_i    (host_we_i),
      .host_adr_i   (host_adr_i),
      .host_sel_i   (host_sel_i),
      .host_dat_i   (host_dat_i),
      .host_ack_o   (host_ack_o),
      .host_dat_o   (host_dat_o),
      .host_busy_o  (host_busy_o),
      .fetch_start_i(fetch_start_i),
      .fetch_pc_i   (fetch_pc_i),
      .fetch_stop_i (fetch_stop_i),
      .fetch_stall_i(fetch_stall_i),
      .instr_o      (instr_o),
      .instr_pc_o   (instr_pc_o),
      .instr_valid_o(instr_valid_o)
   );

   // LCG with the numerical recipes constants
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Byte lanes from new_w where sel is set and old bytes elsewhere
   function automatic word_t merge_lanes(word_t old_w, word_t new_w, sel_t sel);
      word_t res;
      for (int i = 0; i < 4; i++) begin
         res[8*i +: 8] = sel[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
      end
      return res;
   endfunction

   task automatic report_mismatch(string msg, word_t got, word_t exp);
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
   endtask

   task automatic report_flag(string msg);
      $display("FAILED at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic begin_test();
      test_no++;
      errors_at_start = errors;
   endtask

   task automatic end_test(string name);
      if (errors == errors_at_start) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         $display("test %0d %s: %0d errors", test_no, name, errors - errors_at_start);
         tests_failed++;
      end
   endtask

   // One host request with busy and ack latency checks from the drive edge
   // junk keeps the strobe up one more cycle with other fields, which must be ignored
   task automatic host_xfer(input logic we, input addr_t adr, input sel_t sel,
                            input word_t dat, input bit junk, output word_t rdata);
      int n;
      int exp_n;
      exp_n = we ? 2 : 3;
      @(posedge clk);
      host_stb_i <= 1'b1;
      host_we_i  <= we;
      host_adr_i <= adr;
      host_sel_i <= sel;
      host_dat_i <= dat;
      @(posedge clk);
      n = 1;
      if (junk) begin
         host_adr_i <= adr - addr_t'(4);
         host_dat_i <= ~dat;
         host_sel_i <= 4'hf;
      end else begin
         host_stb_i <= 1'b0;
      end
      @(negedge clk);
      while (!host_ack_o && n < 20) begin
         assert (host_busy_o) else report_flag("host_busy_o low during a request");
         @(posedge clk);
         n++;
         host_stb_i <= 1'b0;
         @(negedge clk);
      end
      if (!host_ack_o) begin
         $display("Host request to %h was never acknowledged", adr);
         errors++;
      end else begin
         assert (n == exp_n) else report_mismatch("ack latency", word_t'(n), word_t'(exp_n));
         assert (!host_busy_o) else report_flag("host_busy_o still high at ack");
      end
      rdata = host_dat_o;
   endtask

   task automatic write_word(input int widx, input word_t dat, input sel_t sel, input bit junk);
      word_t dummy;
      host_xfer(1'b1, addr_t'(widx * 4), sel, dat, junk, dummy);
      model[widx] = model.exists(widx) ? merge_lanes(model[widx], dat, sel) : dat;
   endtask

   task automatic read_check(input int widx);
      word_t rd;
      host_xfer(1'b0, addr_t'(widx * 4), 4'hf, 32'h0, 1'b0, rd);
      assert (rd == model[widx]) else report_mismatch("host read data", rd, model[widx]);
   endtask

   // Starts a fetch and checks the delivered stream against the model
   task automatic fetch_stream(input addr_t start, input int words, input bit stalls);
      addr_t  exp_pc;
      addr_t  prev_pc;
      instr_t prev_instr;
      bit     prev_hold;
      int     got;
      int     cycles;
      @(posedge clk);
      fetch_start_i <= 1'b1;
      fetch_pc_i    <= start;
      fetch_stall_i <= 1'b0;
      @(posedge clk);
      fetch_start_i <= 1'b0;
      @(negedge clk);
      assert (!instr_valid_o) else report_flag("instr_valid_o high one edge after start");
      @(posedge clk);
      @(negedge clk);
      assert (instr_valid_o) else report_flag("no valid word two edges after start");
      exp_pc    = start;
      got       = 0;
      cycles    = 0;
      prev_hold = 1'b0;
      while (got < words && cycles < words * 8) begin
         // Held word must not move while stalled
         if (prev_hold) begin
            assert (instr_valid_o) else report_flag("instr_valid_o dropped under stall");
            assert (instr_o == prev_instr) else report_mismatch("instr_o under stall",
                                                                 instr_o, prev_instr);
            assert (instr_pc_o == prev_pc) else report_mismatch("instr_pc_o under stall",
                                                                 32'(instr_pc_o), 32'(prev_pc));
         end
         if (instr_valid_o && !fetch_stall_i) begin
            assert (instr_pc_o == exp_pc) else report_mismatch("instr_pc_o",
                                                                32'(instr_pc_o), 32'(exp_pc));
            assert (instr_o == model[int'(exp_pc >> 2)]) else
               report_mismatch("instr_o", instr_o, model[int'(exp_pc >> 2)]);
            exp_pc = exp_pc + addr_t'(4);
            got++;
         end
         prev_hold  = instr_valid_o && fetch_stall_i;
         prev_instr = instr_o;
         prev_pc    = instr_pc_o;
         @(posedge clk);
         fetch_stall_i <= stalls ? (next_rand() % 3 == 0) : 1'b0;
         cycles++;
         @(negedge clk);
      end
      if (got < words) begin
         $display("Fetch stream stopped after %0d of %0d words", got, words);
         errors++;
      end
   endtask

   task automatic stop_fetch();
      @(posedge clk);
      fetch_stall_i <= 1'b0;
      fetch_stop_i  <= 1'b1;
      @(negedge clk);
      assert (instr_valid_o) else report_flag("instr_valid_o low before the stop edge");
      @(posedge clk);
      fetch_stop_i <= 1'b0;
      @(negedge clk);
      assert (!instr_valid_o) else report_flag("instr_valid_o high after stop");
   endtask

   // Watchdog allows ten cycles per planned transaction plus a margin
   initial begin
      #((PLANNED_TXN * 10 + 2000) * CLK_NS);
      $display("Watchdog expired before the tests finished");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      lcg_state     = 32'hafdee4ff;
      errors        = 0;
      test_no       = 0;
      tests_failed  = 0;
      wb_rst_i      = 1'b1;
      host_stb_i    = 1'b0;
      host_we_i     = 1'b0;
      host_adr_i    = '0;
      host_sel_i    = '0;
      host_dat_i    = '0;
      fetch_start_i = 1'b0;
      fetch_pc_i    = '0;
      fetch_stop_i  = 1'b0;
      fetch_stall_i = 1'b0;

      begin_test();
      for (int i = 0; i < 9; i++) begin
         @(posedge clk);
         if (i == 7) begin
            wb_rst_i <= 1'b0;
         end
         @(negedge clk);
         assert (!host_ack_o && !host_busy_o && !instr_valid_o) else
            report_flag("outputs not low around reset");
      end
      end_test("reset state");

      // Word indices 256..271 with a busy strobe tried on every write
      begin_test();
      for (int i = 0; i < 16; i++) begin
         write_word(256 + i, next_rand(), 4'hf, 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         read_check(256 + i);
      end
      end_test("word write and read");

      begin_test();
      for (int i = 0; i < 16; i++) begin
         write_word(256 + i, next_rand(), sel_t'(next_rand()), 1'b0);
      end
      for (int i = 0; i < 16; i++) begin
         read_check(256 + i);
      end
      end_test("byte lanes");

      // Program region in lower memory plus both ends for the wrap run
      begin_test();
      prog_base = 1024 + int'(next_rand() % 2048);
      for (int i = 0; i < 96; i++) begin
         write_word(prog_base + i, next_rand(), 4'hf, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         write_word(8184 + i, next_rand(), 4'hf, 1'b0);
         write_word(i, next_rand(), 4'hf, 1'b0);
      end
      fetch_stream(addr_t'((prog_base + int'(next_rand() % 16)) * 4), 32, 1'b0);
      stop_fetch();
      fetch_stream(addr_t'(8188 * 4), 12, 1'b0);
      stop_fetch();
      end_test("sequential fetch");

      begin_test();
      fetch_stream(addr_t'(prog_base * 4), 64, 1'b1);
      stop_fetch();
      end_test("stall back-pressure");

      // Host reads on the data port while the fetch port streams
      begin_test();
      fork
         fetch_stream(addr_t'(prog_base * 4), 24, 1'b0);
         for (int i = 0; i < 6; i++) begin
            read_check(256 + int'(next_rand() % 16));
         end
      join
      stop_fetch();
      end_test("dual port and stop");

      $display("tests run %0d, tests failed %0d, failed checks %0d",
               test_no, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/dwb_if.sv
`timescale 1ns/1ps
`default_nettype none

// Data-side Wishbone-style bus between the host bridge and the RAM
interface dwb_if
   import mem_pkg::*;
#(
   parameter int AWIDTH = AWIDTH_DEF
) ();

   logic [AWIDTH-1:0] adr;
   word_t             dat_w;
   word_t             dat_r;
   logic              we;
   logic              stb;
   sel_t              sel;
   logic              ack;

   // Bridge side, owns the request fields
   modport master (
      output adr, dat_w, we, stb, sel,
      input  dat_r, ack
   );

   // RAM side, answers with data and acknowledge
   modport slave (
      input  adr, dat_w, we, stb, sel,
      output dat_r, ack
   );

endinterface

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

// Types seen by the instruction fetch side
package fetch_pkg;

   // Fetch sequencer states
   // Idle until a start, then runs until a stop
   typedef enum logic {
      FETCH_IDLE = 1'b0,
      FETCH_RUN  = 1'b1
   } fetch_state_t;

   // One instruction word as returned by the fetch port
   typedef logic [31:0] instr_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Sequential instruction fetcher
// Walks word addresses from a start PC, one word per unstalled cycle
module fetch_unit
   import fetch_pkg::*;
#(
   parameter int AWIDTH = 15
) (
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   // Control
   input  logic              fetch_start_i,
   input  logic [AWIDTH-1:0] fetch_pc_i,
   input  logic              fetch_stop_i,
   input  logic              fetch_stall_i,
   // RAM fetch port
   output logic [AWIDTH-1:0] if_adr_o,
   input  instr_t            if_data_i,
   // Delivered instruction stream
   output instr_t            instr_o,
   output logic [AWIDTH-1:0] instr_pc_o,
   output logic              instr_valid_o
);

   fetch_state_t      state_q;

   // Next address to issue
   logic [AWIDTH-1:0] pc_q;

   // Address whose word sits in the RAM output register
   logic [AWIDTH-1:0] issued_q;

   logic              valid_q;
   logic              advance;

   // Step only when running and the consumer takes the word
   assign advance = (state_q == FETCH_RUN) & ~fetch_stall_i;

   // On stall re-read the word already on the output
   // so the RAM register keeps the same data
   assign if_adr_o = fetch_stall_i ? issued_q : pc_q;

   // RAM data is already registered, one cycle behind the issued address
   assign instr_o       = if_data_i;
   assign instr_pc_o    = issued_q;
   assign instr_valid_o = valid_q;

   // State and valid flag
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= FETCH_IDLE;
         valid_q <= 1'b0;
      end else if (fetch_start_i) begin
         // Restart, nothing valid until the first read lands
         state_q <= FETCH_RUN;
         valid_q <= 1'b0;
      end else if (fetch_stop_i) begin
         state_q <= FETCH_IDLE;
         valid_q <= 1'b0;
      end else if (advance) begin
         valid_q <= 1'b1;
      end
   end

   // Address pipeline
   always_ff @(posedge wb_clk_i) begin
      if (fetch_start_i) begin
         // Force word alignment
         pc_q <= {fetch_pc_i[AWIDTH-1:2], 2'b00};
      end else if (advance) begin
         // Wraps at the top of the address space
         pc_q     <= pc_q + AWIDTH'(4);
         issued_q <= pc_q;
      end
   end

endmodule

`default_nettype wire

//--- rtl/harvard_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// Harvard memory subsystem
// Host bridge loads the RAM, fetch unit streams it out
module harvard_mem_top
   import mem_pkg::*;
   import fetch_pkg::*;
#(
   parameter int AWIDTH   = AWIDTH_DEF,
   parameter int RAM_SIZE = RAM_SIZE_DEF
) (
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   // Host side
   input  logic              host_stb_i,
   input  logic              host_we_i,
   input  logic [AWIDTH-1:0] host_adr_i,
   input  sel_t              host_sel_i,
   input  word_t             host_dat_i,
   output logic              host_ack_o,
   output word_t             host_dat_o,
   output logic              host_busy_o,
   // Fetch control
   input  logic              fetch_start_i,
   input  logic [AWIDTH-1:0] fetch_pc_i,
   input  logic              fetch_stop_i,
   input  logic              fetch_stall_i,
   // Instruction stream
   output instr_t            instr_o,
   output logic [AWIDTH-1:0] instr_pc_o,
   output logic              instr_valid_o
);

   // Fetch port wiring
   logic [AWIDTH-1:0] if_adr;
   word_t             if_data;

   // Data-side bus
   dwb_if #(.AWIDTH(AWIDTH)) dwb ();

   host_bridge #(
      .AWIDTH(AWIDTH)
   ) u_host_bridge (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .host_stb_i (host_stb_i),
      .host_we_i  (host_we_i),
      .host_adr_i (host_adr_i),
      .host_sel_i (host_sel_i),
      .host_dat_i (host_dat_i),
      .host_ack_o (host_ack_o),
      .host_dat_o (host_dat_o),
      .host_busy_o(host_busy_o),
      .bus        (dwb.master)
   );

   harvard_ram #(
      .AWIDTH  (AWIDTH),
      .RAM_SIZE(RAM_SIZE)
   ) u_ram (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .if_adr_i (if_adr),
      .if_data_o(if_data),
      .bus      (dwb.slave)
   );

   fetch_unit #(
      .AWIDTH(AWIDTH)
   ) u_fetch (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .fetch_start_i(fetch_start_i),
      .fetch_pc_i   (fetch_pc_i),
      .fetch_stop_i (fetch_stop_i),
      .fetch_stall_i(fetch_stall_i),
      .if_adr_o     (if_adr),
      .if_data_i    (if_data),
      .instr_o      (instr_o),
      .instr_pc_o   (instr_pc_o),
      .instr_valid_o(instr_valid_o)
   );

endmodule

`default_nettype wire

//--- rtl/harvard_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Dual-port byte-laned RAM
// Port A is the read-only fetch port, port B the read/write data port
module harvard_ram
   import mem_pkg::*;
#(
   parameter int AWIDTH   = AWIDTH_DEF,
   parameter int RAM_SIZE = RAM_SIZE_DEF
) (
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   // Fetch port
   input  logic [AWIDTH-1:0] if_adr_i,
   output word_t             if_data_o,
   // Data port
   dwb_if.slave              bus
);

   // Entries per byte lane
   localparam int WORDS = RAM_SIZE / 4;

   // Word indices, byte offset dropped
   logic [AWIDTH-3:0] if_word;
   logic [AWIDTH-3:0] dat_word;

   // Ack bookkeeping
   logic              stb_d1;
   logic              ack_d1;

   assign if_word  = if_adr_i[AWIDTH-1:2];
   assign dat_word = bus.adr[AWIDTH-1:2];

   // Writes ack at once
   // Reads ack in the second stb cycle, once per held strobe
   assign bus.ack = bus.stb & (bus.we | (stb_d1 & ~ack_d1));

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         stb_d1 <= 1'b0;
         ack_d1 <= 1'b0;
      end else begin
         stb_d1 <= bus.stb;
         ack_d1 <= bus.ack;
      end
   end

   // One byte-wide array per lane
   for (genvar i = 0; i < 4; i++) begin : g_lane
      logic [7:0] mem [0:WORDS-1];
      logic [7:0] if_q;
      logic [7:0] dat_q;

      // Fetch read every cycle
      always_ff @(posedge wb_clk_i) begin
         if_q <= mem[if_word];
      end

      // Data read only while strobed
      always_ff @(posedge wb_clk_i) begin
         if (bus.stb) begin
            dat_q <= mem[dat_word];
         end
      end

      // Lane write
      always_ff @(posedge wb_clk_i) begin
         if (bus.stb && bus.we && bus.sel[i]) begin
            mem[dat_word] <= bus.dat_w[8*i +: 8];
         end
      end
   end

   // Reassemble lanes, lane 3 is the top byte
   assign if_data_o = {g_lane[3].if_q, g_lane[2].if_q,
                       g_lane[1].if_q, g_lane[0].if_q};

   assign bus.dat_r = {g_lane[3].dat_q, g_lane[2].dat_q,
                       g_lane[1].dat_q, g_lane[0].dat_q};

endmodule

`default_nettype wire

//--- rtl/host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// Host strobe to bus cycle bridge
// One request in flight, stb held until the RAM acknowledges
module host_bridge
   import mem_pkg::*;
#(
   parameter int AWIDTH = AWIDTH_DEF
) (
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   // Host request strobes
   input  logic              host_stb_i,
   input  logic              host_we_i,
   input  logic [AWIDTH-1:0] host_adr_i,
   input  sel_t              host_sel_i,
   input  word_t             host_dat_i,
   // Host completion
   output logic              host_ack_o,
   output word_t             host_dat_o,
   output logic              host_busy_o,
   // Data-side bus
   dwb_if.master             bus
);

   // Outstanding request flag, doubles as bus stb
   logic              stb_q;

   // Held request fields
   logic              we_q;
   logic [AWIDTH-1:0] adr_q;
   sel_t              sel_q;
   word_t             dat_q;

   logic              take;
   logic              done;

   // New request only accepted when nothing is outstanding
   assign take = host_stb_i & ~stb_q;

   // Bus cycle ends in the cycle the RAM acks
   assign done = stb_q & bus.ack;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         stb_q      <= 1'b0;
         host_ack_o <= 1'b0;
      end else begin
         // One-cycle pulse right after the ack edge
         host_ack_o <= done;
         if (take) begin
            stb_q <= 1'b1;
         end else if (done) begin
            stb_q <= 1'b0;
         end
      end
   end

   // Request capture
   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         we_q  <= host_we_i;
         adr_q <= host_adr_i;
         sel_q <= host_sel_i;
         dat_q <= host_dat_i;
      end
   end

   // Read word kept until the next read completes
   always_ff @(posedge wb_clk_i) begin
      if (done && !we_q) begin
         host_dat_o <= bus.dat_r;
      end
   end

   // Busy drops together with the ack pulse
   assign host_busy_o = stb_q;

   // Request fields stay steady for the whole cycle
   assign bus.stb   = stb_q;
   assign bus.we    = we_q;
   assign bus.adr   = adr_q;
   assign bus.sel   = sel_q;
   assign bus.dat_w = dat_q;

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

// Memory geometry and data-side bus types
package mem_pkg;

   // Default byte address width, 32 KiB of RAM
   localparam int AWIDTH_DEF = 15;

   // Default RAM size in bytes
   localparam int RAM_SIZE_DEF = 32768;

   // One 32-bit data word on the data port
   typedef logic [31:0] word_t;

   // Byte-lane select, bit n enables bits 8n+7..8n
   typedef logic [3:0] sel_t;

   // Byte address at the default width
   typedef logic [AWIDTH_DEF-1:0] addr_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the Harvard memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_harvard_mem \
   --Mdir obj_dir -o tb_sim \
   -f sim.f

out=$(./obj_dir/tb_sim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -q "^Simulation PASSED$"

//--- sim.f
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/dwb_if.sv
rtl/host_bridge.sv
rtl/harvard_ram.sv
rtl/fetch_unit.sv
rtl/harvard_mem_top.sv
bench/tb_clkgen.sv
bench/tb_harvard_mem.sv
